// ==== mouse_timeout_timer.sv ====
//======================================
// Mouse read stall detector
// Counts cycles with clr low, saturates
//======================================

`timescale 1ns/1ns
`default_nettype none

module mouse_timeout_timer #(
	parameter int TIMEOUT_BITS = 15
) (
	input  wire                         clk_sys,
	input  wire                         reset,
	input  wire pce_pad_pkg::port_lines_t lines,
	output logic                        timed_out
);

	logic [TIMEOUT_BITS-1:0] count;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			count <= '0;
		end else if (lines.clr) begin
			count <= '0;
		end else if (~&count) begin
			count <= count + 1'b1;
		end
	end

	// High while the counter sits at all ones
	assign timed_out = &count;

endmodule

`default_nettype wire

// ==== mouse_tracker.sv ====
//======================================
// Mouse motion for the four-nibble read
// X is negated to match the console axis
// Latest sample replaces the pending one
//======================================

`timescale 1ns/1ns
`default_nettype none

module mouse_tracker (
	input  wire                           clk_sys,
	input  wire                           reset,
	input  wire pce_pad_pkg::mouse_delta_t mouse_dx,
	input  wire pce_pad_pkg::mouse_delta_t mouse_dy,
	input  wire                           mouse_strobe,
	input  wire                           clr_rise,
	input  wire                           timed_out,
	output pce_pad_pkg::port_nibble_t     motion_nibble
);

	pce_pad_pkg::mouse_delta_t pending_x;
	pce_pad_pkg::mouse_delta_t pending_y;
	pce_pad_pkg::mouse_delta_t shown_x;
	pce_pad_pkg::mouse_delta_t shown_y;
	logic [1:0] nibble_cnt;

	//======================================
	// Counter and motion registers
	//======================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			nibble_cnt <= 2'd3;
			pending_x  <= '0;
			pending_y  <= '0;
			shown_x    <= '0;
			shown_y    <= '0;
		end else begin
			// Stalled read, next clr starts at X high
			if (timed_out)
				nibble_cnt <= 2'd3;

			if (clr_rise) begin
				nibble_cnt <= nibble_cnt + 2'd1;
				if (&nibble_cnt) begin
					// New read cycle, publish pending motion
					shown_x   <= pending_x;
					shown_y   <= pending_y;
					pending_x <= '0;
					pending_y <= '0;
				end
			end

			// A fresh sample wins over the clear above
			if (mouse_strobe) begin
				pending_x <= 8'd0 - mouse_dx;
				pending_y <= mouse_dy;
			end
		end
	end

	//======================================
	// Nibble select
	//======================================

	always_comb begin
		case (nibble_cnt)
			2'd0:    motion_nibble = shown_x[7:4];
			2'd1:    motion_nibble = shown_x[3:0];
			2'd2:    motion_nibble = shown_y[7:4];
			default: motion_nibble = shown_y[3:0];
		endcase
	end

endmodule

`default_nettype wire

// ==== pad_encoder.sv ====
//======================================
// Port word encoding and joy_in register
// All pad nibbles are active low
// Mouse replaces pad 0 when enabled
//======================================

`timescale 1ns/1ns
`default_nettype none

module pad_encoder (
	input  wire                           clk_sys,
	input  wire                           reset,
	input  wire pce_pad_pkg::pad_config_t   cfg,
	input  wire pce_pad_pkg::port_lines_t   lines,
	input  wire pce_pad_pkg::pad_set_t      pads,
	input  wire                           mouse_left,
	input  wire                           mouse_right,
	input  wire pce_pad_pkg::port_index_t   port_index,
	input  wire                           high_bank,
	input  wire pce_pad_pkg::port_nibble_t  motion_nibble,
	output pce_pad_pkg::port_nibble_t     joy_in
);

	pce_pad_pkg::pad_set_t pads_sw;
	pce_pad_pkg::pad_word_t port_word;
	pce_pad_pkg::port_nibble_t nibble;
	logic [7:0] mouse_byte;
	logic [1:0] nib_sel;

	// Nibble 0 run/select/II/I, nibble 1 left/down/right/up, nibble 2 VI-III
	function automatic pce_pad_pkg::pad_word_t encode_pad(input pce_pad_pkg::pad_buttons_t b);
		return ~{4'hF, b[11:8], b[1], b[2], b[0], b[3], b[7:4]};
	endfunction

	always_comb begin
		pads_sw = pads;
		if (cfg.joy_swap) begin
			pads_sw[0] = pads[1];
			pads_sw[1] = pads[0];
		end
	end

	// Motion in the high nibble, buttons low
	assign mouse_byte = {motion_nibble,
		~{pads_sw[0][7], pads_sw[0][6], mouse_left, mouse_right}};

	always_comb begin
		if (port_index >= pce_pad_pkg::port_index_t'(pce_pad_pkg::NUM_PADS))
			port_word = pce_pad_pkg::NO_PAD_WORD;
		else if (port_index == '0 && cfg.mouse_en)
			port_word = {mouse_byte, mouse_byte};
		else
			port_word = encode_pad(pads_sw[port_index]);
	end

	assign nib_sel = {high_bank, lines.sel};
	assign nibble  = port_word[{nib_sel, 2'b00} +: 4];

	//======================================
	// Output register
	//======================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			joy_in <= '0;
		end else if (lines.clr) begin
			joy_in <= '0;
		end else begin
			joy_in <= nibble;
		end
	end

endmodule

`default_nettype wire

// ==== pad_scan_fsm.sv ====
//======================================
// Turbo-tap scanner and six-button bank
// Lines are sampled every cycle
// Index holds once past the last pad
//======================================

`timescale 1ns/1ns
`default_nettype none

module pad_scan_fsm #(
	parameter int NUM_PADS = 5
) (
	input  wire                         clk_sys,
	input  wire                         reset,
	input  wire pce_pad_pkg::pad_config_t cfg,
	input  wire pce_pad_pkg::port_lines_t lines,
	output pce_pad_pkg::port_index_t    port_index,
	output logic                        high_bank,
	output logic                        clr_rise
);

	typedef enum logic [1:0] {
		scan_clear,
		scan_pad,
		scan_past_end
	} scan_state_t;

	scan_state_t state;
	logic last_clr;
	logic last_sel;
	pce_pad_pkg::port_index_t next_index;

	assign next_index = port_index + 3'd1;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= scan_clear;
			port_index <= '0;
			high_bank  <= 1'b0;
			clr_rise   <= 1'b0;
			last_clr   <= 1'b0;
			last_sel   <= 1'b0;
		end else begin
			last_clr <= lines.clr;
			last_sel <= lines.sel;
			clr_rise <= lines.clr & ~last_clr;

			if (lines.clr) begin
				// Clear restarts the scan at port 0
				state      <= scan_clear;
				port_index <= '0;
				if (~last_clr) begin
					// Alternate banks only in six-button mode
					high_bank <= ~high_bank & cfg.buttons6;
				end
			end else if (lines.sel & ~last_sel & cfg.turbotap) begin
				case (state)
					scan_clear, scan_pad: begin
						port_index <= next_index;
						if (next_index >= pce_pad_pkg::port_index_t'(NUM_PADS))
							state <= scan_past_end;
						else
							state <= scan_pad;
					end
					default: begin
						// Stay on the empty port until the next clear
						state <= scan_past_end;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== pce_pad_bridge.f ====
pce_pad_pkg.sv
pad_scan_fsm.sv
mouse_timeout_timer.sv
mouse_tracker.sv
pad_encoder.sv
pce_pad_bridge.sv
tb_clock_gen.sv
tb_pad_checker.sv
tb_pce_pad_bridge.sv

// ==== pce_pad_bridge.sv ====
//======================================
// Pads and mouse to console port nibbles
// joy_in is registered, one cycle latency
// Mouse is only offered on port 0
//======================================

`timescale 1ns/1ns
`default_nettype none

module pce_pad_bridge #(
	parameter int MOUSE_TIMEOUT_BITS = 15
) (
	input  wire                           clk_sys,
	input  wire                           reset,
	input  wire pce_pad_pkg::pad_config_t   cfg,
	input  wire pce_pad_pkg::pad_set_t      pads,
	input  wire pce_pad_pkg::mouse_delta_t  mouse_dx,
	input  wire pce_pad_pkg::mouse_delta_t  mouse_dy,
	input  wire                           mouse_strobe,
	input  wire                           mouse_left,
	input  wire                           mouse_right,
	input  wire pce_pad_pkg::port_lines_t   lines,
	output pce_pad_pkg::port_nibble_t     joy_in
);

	pce_pad_pkg::port_index_t port_index;
	pce_pad_pkg::port_nibble_t motion_nibble;
	logic high_bank;
	logic clr_rise;
	logic timed_out;

	pad_scan_fsm #(
		.NUM_PADS(pce_pad_pkg::NUM_PADS)
	) i_scan (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cfg        (cfg),
		.lines      (lines),
		.port_index (port_index),
		.high_bank  (high_bank),
		.clr_rise   (clr_rise)
	);

	mouse_timeout_timer #(
		.TIMEOUT_BITS(MOUSE_TIMEOUT_BITS)
	) i_timeout (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.lines     (lines),
		.timed_out (timed_out)
	);

	mouse_tracker i_mouse (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.mouse_dx      (mouse_dx),
		.mouse_dy      (mouse_dy),
		.mouse_strobe  (mouse_strobe),
		.clr_rise      (clr_rise),
		.timed_out     (timed_out),
		.motion_nibble (motion_nibble)
	);

	pad_encoder i_encoder (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cfg           (cfg),
		.lines         (lines),
		.pads          (pads),
		.mouse_left    (mouse_left),
		.mouse_right   (mouse_right),
		.port_index    (port_index),
		.high_bank     (high_bank),
		.motion_nibble (motion_nibble),
		.joy_in        (joy_in)
	);

endmodule

`default_nettype wire

// ==== pce_pad_pkg.sv ====
//======================================
// Shared types for the controller port
// Buttons are active high at the input
// Port nibbles are active low on the bus
//======================================

`default_nettype none

package pce_pad_pkg;

	//======================================
	// Port counts
	//======================================

	// Turbo-tap positions that hold a pad
	parameter int NUM_PADS = 5;

	//======================================
	// Plain vector types
	//======================================

	// One pad, bit 0 right .. bit 7 run, bits 8-11 buttons III-VI
	typedef logic [11:0] pad_buttons_t;

	// Four nibbles one port can present
	typedef logic [15:0] pad_word_t;

	// Value on the data lines
	typedef logic [3:0] port_nibble_t;

	// Turbo-tap position, 5 and up is an empty port
	typedef logic [2:0] port_index_t;

	// Signed mouse motion per sample
	typedef logic [7:0] mouse_delta_t;

	//======================================
	// Structs and arrays
	//======================================

	typedef struct packed {
		logic joy_swap;
		logic turbotap;
		logic buttons6;
		logic mouse_en;
	} pad_config_t;

	// Lines driven by the console
	typedef struct packed {
		logic clr;
		logic sel;
	} port_lines_t;

	typedef pad_buttons_t [NUM_PADS-1:0] pad_set_t;

	// Empty port reads all ones except the ID nibble
	parameter pad_word_t NO_PAD_WORD = 16'h0FFF;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/bash
# Build and run the testbench with Verilator, result taken from sim.log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --top-module tb_pce_pad_bridge \
	-f pce_pad_bridge.f -o tb_sim > build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

grep -q "^SIMULATION PASSED$" sim.log && echo "Run passed" \
	|| { echo "Run failed"; exit 1; }

// ==== tb_clock_gen.sv ====
//======================================
// Testbench clock and reset
// 40 ns period, reset high for 10 cycles
//======================================

`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	initial begin
		reset = 1'b1;
		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== tb_pad_checker.sv ====
//======================================
// Compares joy_in once per check request
// Prints one line per step and the totals
//======================================

`timescale 1ns/1ns
`default_nettype none

module tb_pad_checker (
	input  wire                           clk_sys,
	input  wire                           check_en,
	input  wire                           report_en,
	input  wire [127:0]                   step_name,
	input  wire [3:0]                     expected,
	input  wire pce_pad_pkg::port_nibble_t joy_in,
	output int                            check_count,
	output int                            error_count,
	output logic                          report_done
);

	initial begin
		check_count = 0;
		error_count = 0;
		report_done = 1'b0;
	end

	// joy_in is sampled at the edge, the value the DUT held for the cycle
	always @(posedge clk_sys) begin
		if (check_en) begin
			if (joy_in !== expected) begin
				$display("Mismatch step %0d %0s expected %h actual %h",
					check_count, step_name, expected, joy_in);
				error_count <= error_count + 1;
			end else begin
				$display("Pass step %0d %0s joy_in %h", check_count, step_name, joy_in);
			end
			check_count <= check_count + 1;
		end
		if (report_en) begin
			$display("Checks run %0d, errors %0d", check_count, error_count);
			report_done <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== tb_pce_pad_bridge.sv ====
//======================================
// Testbench for the controller port bridge
// Expected nibbles come from a port model
// Mouse timeout is shortened to 6 bits
//======================================

`timescale 1ns/1ns
`default_nettype none

module tb_pce_pad_bridge;

	typedef struct packed {
		logic [127:0]              name;
		pce_pad_pkg::pad_config_t  cfg;
		pce_pad_pkg::pad_set_t     pads;
		pce_pad_pkg::mouse_delta_t dx;
		pce_pad_pkg::mouse_delta_t dy;
		pce_pad_pkg::port_lines_t  lines;
		logic                      strobe;
		logic [7:0]                hold;
		pce_pad_pkg::port_nibble_t expected;
	} step_t;

	// Bit order joy_swap, turbotap, buttons6, mouse_en
	localparam pce_pad_pkg::pad_config_t CFG_NONE  = 4'b0000;
	localparam pce_pad_pkg::pad_config_t CFG_TAP   = 4'b0100;
	localparam pce_pad_pkg::pad_config_t CFG_SIX   = 4'b0010;
	localparam pce_pad_pkg::pad_config_t CFG_SWAP  = 4'b1000;
	localparam pce_pad_pkg::pad_config_t CFG_MOUSE = 4'b0001;

	logic clk_sys;
	logic reset;
	pce_pad_pkg::pad_config_t cfg;
	pce_pad_pkg::pad_set_t pads;
	pce_pad_pkg::mouse_delta_t mouse_dx;
	pce_pad_pkg::mouse_delta_t mouse_dy;
	logic mouse_strobe;
	logic mouse_left;
	logic mouse_right;
	pce_pad_pkg::port_lines_t lines;
	pce_pad_pkg::port_nibble_t joy_in;

	logic check_en;
	logic report_en;
	logic [127:0] step_name;
	logic [3:0] expected;
	int check_count;
	int error_count;
	logic report_done;

	step_t steps[$];
	int seed;
	logic hang;

	// Port model state
	int m_idx;
	logic m_bank;
	logic [1:0] m_cnt;
	logic [7:0] m_pend_x;
	logic [7:0] m_pend_y;
	logic [7:0] m_shown_x;
	logic [7:0] m_shown_y;
	logic m_prev_clr;
	logic m_prev_sel;
	int m_low;
	logic [7:0] cur_dx;
	logic [7:0] cur_dy;

	tb_clock_gen i_clock (
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	pce_pad_bridge #(
		.MOUSE_TIMEOUT_BITS(6)
	) i_dut (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cfg          (cfg),
		.pads         (pads),
		.mouse_dx     (mouse_dx),
		.mouse_dy     (mouse_dy),
		.mouse_strobe (mouse_strobe),
		.mouse_left   (mouse_left),
		.mouse_right  (mouse_right),
		.lines        (lines),
		.joy_in       (joy_in)
	);

	tb_pad_checker i_checker (
		.clk_sys     (clk_sys),
		.check_en    (check_en),
		.report_en   (report_en),
		.step_name   (step_name),
		.expected    (expected),
		.joy_in      (joy_in),
		.check_count (check_count),
		.error_count (error_count),
		.report_done (report_done)
	);

	//======================================
	// Port model
	//======================================

	// Buttons to the active-low word with a zero ID nibble
	function automatic logic [15:0] encode_word(input logic [11:0] b);
		logic [15:0] w;
		w[0]     = ~b[4];
		w[1]     = ~b[5];
		w[2]     = ~b[6];
		w[3]     = ~b[7];
		w[4]     = ~b[3];
		w[5]     = ~b[0];
		w[6]     = ~b[2];
		w[7]     = ~b[1];
		w[11:8]  = ~b[11:8];
		w[15:12] = 4'h0;
		return w;
	endfunction

	task automatic add_step(input logic [127:0] name, input pce_pad_pkg::pad_config_t c,
		input logic clr, input logic sel, input logic strobe, input int hold);
		step_t s;
		pce_pad_pkg::pad_set_t sw;
		logic [15:0] word;
		logic [7:0] mb;
		logic [3:0] motion;
		s.name = name;
		s.cfg  = c;
		for (int i = 0; i < pce_pad_pkg::NUM_PADS; i++)
			s.pads[i] = 12'($random(seed));
		s.dx        = cur_dx;
		s.dy        = cur_dy;
		s.lines.clr = clr;
		s.lines.sel = sel;
		s.strobe    = strobe;
		s.hold      = 8'(hold);

		if (clr) begin
			if (!m_prev_clr) begin
				m_bank = c.buttons6 ? ~m_bank : 1'b0;
				if (m_cnt == 2'd3) begin
					m_shown_x = m_pend_x;
					m_shown_y = m_pend_y;
					m_pend_x  = 8'h00;
					m_pend_y  = 8'h00;
				end
				m_cnt = m_cnt + 2'd1;
			end
			m_idx = 0;
			m_low = 0;
		end else begin
			if (sel && !m_prev_sel && c.turbotap && m_idx < 5)
				m_idx = m_idx + 1;
			m_low = m_low + hold + 3;
			// Long idle restarts the mouse read
			if (m_low >= 63)
				m_cnt = 2'd3;
		end
		if (strobe) begin
			m_pend_x = 8'h00 - cur_dx;
			m_pend_y = cur_dy;
		end
		m_prev_clr = clr;
		m_prev_sel = sel;

		sw = s.pads;
		if (c.joy_swap) begin
			sw[0] = s.pads[1];
			sw[1] = s.pads[0];
		end
		case (m_cnt)
			2'd0:    motion = m_shown_x[7:4];
			2'd1:    motion = m_shown_x[3:0];
			2'd2:    motion = m_shown_y[7:4];
			default: motion = m_shown_y[3:0];
		endcase
		mb = {motion, ~sw[0][7], ~sw[0][6], ~mouse_left, ~mouse_right};
		if (m_idx >= 5)
			word = 16'h0FFF;
		else if (m_idx == 0 && c.mouse_en)
			word = {mb, mb};
		else
			word = encode_word(sw[m_idx]);

		if (clr)
			s.expected = 4'h0;
		else
			s.expected = word[{m_bank, sel, 2'b00} +: 4];
		steps.push_back(s);
	endtask

	task automatic build_table();
		// Plain pad 0 reads
		add_step("clr_high", CFG_NONE, 1'b1, 1'b0, 1'b0, 3);
		add_step("pad0_nib0", CFG_NONE, 1'b0, 1'b0, 1'b0, 3);
		add_step("pad0_nib1", CFG_NONE, 1'b0, 1'b1, 1'b0, 3);
		add_step("pad0_nib0_again", CFG_NONE, 1'b0, 1'b0, 1'b0, 3);

		// Turbo-tap scan where the fifth advance lands on the empty port
		add_step("tap_clr", CFG_TAP, 1'b1, 1'b0, 1'b0, 3);
		add_step("tap_pad0", CFG_TAP, 1'b0, 1'b0, 1'b0, 3);
		for (int p = 0; p < 5; p++) begin
			add_step("tap_advance", CFG_TAP, 1'b0, 1'b1, 1'b0, 3);
			add_step("tap_low_nib", CFG_TAP, 1'b0, 1'b0, 1'b0, 3);
		end
		add_step("tap_past_end", CFG_TAP, 1'b0, 1'b1, 1'b0, 3);
		add_step("notap_clr", CFG_NONE, 1'b1, 1'b0, 1'b0, 3);
		add_step("notap_sel_hi", CFG_NONE, 1'b0, 1'b1, 1'b0, 3);
		add_step("notap_sel_lo", CFG_NONE, 1'b0, 1'b0, 1'b0, 3);
		add_step("notap_sel_hi2", CFG_NONE, 1'b0, 1'b1, 1'b0, 3);

		// Six-button banks alternate on each clear
		for (int k = 0; k < 3; k++) begin
			add_step("six_clr", CFG_SIX, 1'b1, 1'b0, 1'b0, 3);
			add_step("six_sel_lo", CFG_SIX, 1'b0, 1'b0, 1'b0, 3);
			add_step("six_sel_hi", CFG_SIX, 1'b0, 1'b1, 1'b0, 3);
		end
		add_step("six_off_clr", CFG_NONE, 1'b1, 1'b0, 1'b0, 3);
		add_step("six_off_lo", CFG_NONE, 1'b0, 1'b0, 1'b0, 3);
		add_step("six_off_hi", CFG_NONE, 1'b0, 1'b1, 1'b0, 3);

		// Joystick swap
		add_step("swap_clr", CFG_SWAP, 1'b1, 1'b0, 1'b0, 3);
		add_step("swap_lo", CFG_SWAP, 1'b0, 1'b0, 1'b0, 3);
		add_step("swap_hi", CFG_SWAP, 1'b0, 1'b1, 1'b0, 3);

		// Mouse sample then four nibble reads
		cur_dx = 8'h15;
		cur_dy = 8'h9C;
		add_step("mouse_clr", CFG_MOUSE, 1'b1, 1'b0, 1'b0, 3);
		add_step("mouse_idle", CFG_MOUSE, 1'b0, 1'b0, 1'b0, 80);
		add_step("mouse_strobe", CFG_MOUSE, 1'b0, 1'b0, 1'b1, 3);
		for (int k = 0; k < 4; k++) begin
			add_step("mouse_pulse", CFG_MOUSE, 1'b1, 1'b0, 1'b0, 3);
			add_step("mouse_motion", CFG_MOUSE, 1'b0, 1'b1, 1'b0, 3);
			add_step("mouse_buttons", CFG_MOUSE, 1'b0, 1'b0, 1'b0, 3);
		end

		// Idle timeout in the middle of a read
		cur_dx = 8'h2A;
		cur_dy = 8'h42;
		add_step("tmo_first_strobe", CFG_MOUSE, 1'b0, 1'b0, 1'b1, 3);
		add_step("tmo_pulse", CFG_MOUSE, 1'b1, 1'b0, 1'b0, 3);
		add_step("tmo_x_high", CFG_MOUSE, 1'b0, 1'b1, 1'b0, 3);
		add_step("tmo_pulse", CFG_MOUSE, 1'b1, 1'b0, 1'b0, 3);
		add_step("tmo_x_low", CFG_MOUSE, 1'b0, 1'b1, 1'b0, 3);
		cur_dx = 8'h3B;
		cur_dy = 8'h71;
		add_step("tmo_strobe", CFG_MOUSE, 1'b0, 1'b0, 1'b1, 3);
		add_step("tmo_idle", CFG_MOUSE, 1'b0, 1'b0, 1'b0, 80);
		add_step("tmo_pulse", CFG_MOUSE, 1'b1, 1'b0, 1'b0, 3);
		add_step("tmo_restart", CFG_MOUSE, 1'b0, 1'b1, 1'b0, 3);
	endtask

	//======================================
	// Stimulus
	//======================================

	task automatic wait_cycles(input int n);
		for (int i = 0; i < n; i++)
			@(posedge clk_sys);
	endtask

	initial begin
		int prev;
		int tries;
		step_t s;
		cfg          = CFG_NONE;
		pads         = '0;
		mouse_dx     = '0;
		mouse_dy     = '0;
		mouse_strobe = 1'b0;
		mouse_left   = 1'b1;
		mouse_right  = 1'b0;
		lines        = '0;
		check_en     = 1'b0;
		report_en    = 1'b0;
		step_name    = '0;
		expected     = '0;
		hang         = 1'b0;
		seed         = 32'hd889;
		m_idx        = 0;
		m_bank       = 1'b0;
		m_cnt        = 2'd3;
		m_pend_x     = '0;
		m_pend_y     = '0;
		m_shown_x    = '0;
		m_shown_y    = '0;
		m_prev_clr   = 1'b0;
		m_prev_sel   = 1'b0;
		m_low        = 0;
		cur_dx       = '0;
		cur_dy       = '0;
		build_table();

		tries = 0;
		while (reset === 1'b1 && tries < 50) begin
			@(posedge clk_sys);
			tries++;
		end
		if (reset !== 1'b0) begin
			$display("Reset never released");
			hang = 1'b1;
		end

		for (int i = 0; i < steps.size() && !hang; i++) begin
			s = steps[i];
			@(posedge clk_sys);
			cfg          <= s.cfg;
			pads         <= s.pads;
			mouse_dx     <= s.dx;
			mouse_dy     <= s.dy;
			lines        <= s.lines;
			mouse_strobe <= s.strobe;
			@(posedge clk_sys);
			mouse_strobe <= 1'b0;
			wait_cycles(int'(s.hold) - 1);

			prev = check_count;
			@(posedge clk_sys);
			step_name <= s.name;
			expected  <= s.expected;
			check_en  <= 1'b1;
			@(posedge clk_sys);
			check_en <= 1'b0;
			tries = 0;
			while (check_count == prev && tries < 10) begin
				@(negedge clk_sys);
				tries++;
			end
			if (check_count == prev) begin
				$display("Checker did not answer for step %0d", i);
				hang = 1'b1;
			end
		end

		@(posedge clk_sys);
		report_en <= 1'b1;
		@(posedge clk_sys);
		report_en <= 1'b0;
		tries = 0;
		while (!report_done && tries < 10) begin
			@(negedge clk_sys);
			tries++;
		end
		if (!report_done) begin
			$display("Checker gave no summary");
			hang = 1'b1;
		end

		if (!hang && error_count == 0 && check_count == steps.size()) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
